/* adder_tree.sv */
`timescale 1ns/1ps

module adder_tree
  import conv_geometry_pkg::*, conv_types_pkg::*;
(
  input  logic     clk,
  input  logic     reset,
  input  tap_bus_t tap_bus,
  input  logic     group_done,
  output sum_t     sum,
  output logic     sum_valid
);

  // Heap layout, node 1 is the root and node k feeds from 2k and 2k+1
  sum_t node [1:CHANNEL_NUM-1];

  logic [ADD_LEVELS-1:0] lvl_valid;
  logic [ADD_LEVELS:0] valid_chain;

  ////////////////////////////////////////
  // Pairwise adder levels
  ////////////////////////////////////////

  for (genvar l = 1; l <= ADD_LEVELS; l++) begin : g_level
    for (genvar k = 2**(ADD_LEVELS-l); k < 2**(ADD_LEVELS-l+1); k++) begin : g_node
      if (l == 1) begin : g_leaf
        // First level takes the taps of a finished group
        always_ff @(posedge clk) begin
          if (group_done) begin
            node[k] <= sum_t'($signed(tap_bus.taps[2*k-CHANNEL_NUM]))
                     + sum_t'($signed(tap_bus.taps[2*k+1-CHANNEL_NUM]));
          end
        end
      end else begin : g_inner
        always_ff @(posedge clk) begin
          node[k] <= node[2*k] + node[2*k+1];
        end
      end
    end
  end

  // Valid bit runs beside the data, one bit per level
  always_ff @(posedge clk) begin
    if (reset) begin
      lvl_valid <= '0;
    end else begin
      lvl_valid <= (lvl_valid << 1) | ADD_LEVELS'(group_done);
    end
  end

  assign sum = node[1];
  assign sum_valid = lvl_valid[ADD_LEVELS-1];

  assign valid_chain = {lvl_valid, group_done};

  for (genvar l = 1; l <= ADD_LEVELS; l++) begin : g_valid_chk
    a_level_valid: assert property (
      @(posedge clk) disable iff (reset) valid_chain[l] |-> $past(valid_chain[l-1])
    );
  end

endmodule

/* channel_adder_top.sv */
`timescale 1ns/1ps

module channel_adder_top
  import conv_geometry_pkg::*, conv_types_pkg::*;
(
  input  logic clk,
  input  logic reset,
  input  logic valid_in,
  input  pxl_t pxl_in,
  output pxl_t pxl_out,
  output logic valid_out,
  output logic plane_last
);

  tap_bus_t tap_bus;
  logic group_done;
  sum_t sum;
  logic sum_valid;

  ////////////////////////////////////////
  // Input side
  ////////////////////////////////////////

  plane_delay_line plane_delay_line_i (
    .clk     (clk),
    .reset   (reset),
    .valid_in(valid_in),
    .pxl_in  (pxl_in),
    .tap_bus (tap_bus)
  );

  plane_counter plane_counter_i (
    .clk       (clk),
    .reset     (reset),
    .valid_in  (valid_in),
    .taps_ready(tap_bus.valid),
    .group_done(group_done)
  );

  ////////////////////////////////////////
  // Sum and output side
  ////////////////////////////////////////

  adder_tree adder_tree_i (
    .clk       (clk),
    .reset     (reset),
    .tap_bus   (tap_bus),
    .group_done(group_done),
    .sum       (sum),
    .sum_valid (sum_valid)
  );

  result_clamp result_clamp_i (
    .clk       (clk),
    .reset     (reset),
    .sum       (sum),
    .sum_valid (sum_valid),
    .pxl_out   (pxl_out),
    .valid_out (valid_out),
    .plane_last(plane_last)
  );

endmodule

/* conv_geometry_pkg.sv */
package conv_geometry_pkg;

  ////////////////////////////////////////
  // Channel and plane geometry
  ////////////////////////////////////////

  // Channels summed into one output pixel
  localparam int CHANNEL_NUM = 4;

  // Pixels in one channel plane
  localparam int PLANE_PIXELS = 16;

  // Pairwise adder stages
  localparam int ADD_LEVELS = $clog2(CHANNEL_NUM);

  ////////////////////////////////////////
  // Counter widths
  ////////////////////////////////////////

  localparam int PIXEL_CNT_WIDTH = $clog2(PLANE_PIXELS);
  localparam int CHANNEL_CNT_WIDTH = $clog2(CHANNEL_NUM);

  // Pixels that must enter before every tap holds real data
  localparam int FILL_PIXELS = (CHANNEL_NUM - 1) * PLANE_PIXELS;
  localparam int FILL_CNT_WIDTH = $clog2(FILL_PIXELS + 1);

endpackage

/* conv_types_pkg.sv */
package conv_types_pkg;

  import conv_geometry_pkg::*;

  ////////////////////////////////////////
  // Data widths
  ////////////////////////////////////////

  localparam int PXL_WIDTH = 16;
  localparam int SUM_WIDTH = PXL_WIDTH + ADD_LEVELS;

  typedef logic signed [PXL_WIDTH-1:0] pxl_t;

  // Room for ADD_LEVELS carries out of the tree
  typedef logic signed [SUM_WIDTH-1:0] sum_t;

  // Saturation limits
  localparam pxl_t PXL_MAX = 16'sh7fff;
  localparam pxl_t PXL_MIN = 16'sh8000;

  ////////////////////////////////////////
  // Aligned taps from the delay chain
  ////////////////////////////////////////

  // taps[0] is the newest plane, taps[CHANNEL_NUM-1] the oldest
  typedef struct packed {
    pxl_t [CHANNEL_NUM-1:0] taps;
    logic                   valid;
  } tap_bus_t;

endpackage

/* files.f */
conv_geometry_pkg.sv
conv_types_pkg.sv
plane_delay_line.sv
plane_counter.sv
adder_tree.sv
result_clamp.sv
channel_adder_top.sv
tb_channel_adder.sv

/* plane_counter.sv */
`timescale 1ns/1ps

module plane_counter
  import conv_geometry_pkg::*, conv_types_pkg::*;
(
  input  logic clk,
  input  logic reset,
  input  logic valid_in,
  input  logic taps_ready,
  output logic group_done
);

  logic valid_q;
  logic last_chan_q;
  logic [PIXEL_CNT_WIDTH-1:0] pix_cnt;
  logic [CHANNEL_CNT_WIDTH-1:0] chan_cnt;

  // Steps on the registered strobe, same edge as the tap register
  always_ff @(posedge clk) begin
    if (reset) begin
      valid_q <= 1'b0;
      last_chan_q <= 1'b0;
      pix_cnt <= '0;
      chan_cnt <= '0;
    end else begin
      valid_q <= valid_in;
      last_chan_q <= 1'b0;
      if (valid_q) begin
        last_chan_q <= (chan_cnt == CHANNEL_CNT_WIDTH'(CHANNEL_NUM - 1));
        if (pix_cnt == PIXEL_CNT_WIDTH'(PLANE_PIXELS - 1)) begin
          pix_cnt <= '0;
          if (chan_cnt == CHANNEL_CNT_WIDTH'(CHANNEL_NUM - 1)) begin
            chan_cnt <= '0;
          end else begin
            chan_cnt <= chan_cnt + 1'b1;
          end
        end else begin
          pix_cnt <= pix_cnt + 1'b1;
        end
      end
    end
  end

  // Taps and flag come from the same edge
  assign group_done = last_chan_q & taps_ready;

  a_chan_range: assert property (
    @(posedge clk) disable iff (reset) int'(chan_cnt) < CHANNEL_NUM
  );

endmodule

/* plane_delay_line.sv */
`timescale 1ns/1ps

module plane_delay_line
  import conv_geometry_pkg::*, conv_types_pkg::*;
(
  input  logic     clk,
  input  logic     reset,
  input  logic     valid_in,
  input  pxl_t     pxl_in,
  output tap_bus_t tap_bus
);

  pxl_t in_pxl_q;
  logic in_valid_q;

  // One plane of history per buffer
  pxl_t line_buf [CHANNEL_NUM-1][PLANE_PIXELS];

  pxl_t [CHANNEL_NUM-1:0] taps_q;
  logic taps_valid_q;
  logic [FILL_CNT_WIDTH-1:0] fill_cnt;

  ////////////////////////////////////////
  // Input register
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (valid_in) begin
      in_pxl_q <= pxl_in;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      in_valid_q <= 1'b0;
    end else begin
      in_valid_q <= valid_in;
    end
  end

  ////////////////////////////////////////
  // Plane buffers and tap register
  ////////////////////////////////////////

  // Chain only moves on a strobe, so idle cycles keep alignment
  always_ff @(posedge clk) begin
    if (in_valid_q) begin
      taps_q[0] <= in_pxl_q;
      line_buf[0][0] <= in_pxl_q;
      for (int b = 0; b < CHANNEL_NUM - 1; b++) begin
        // Oldest entry is the same position one plane back
        taps_q[b+1] <= line_buf[b][PLANE_PIXELS-1];
        if (b > 0) begin
          line_buf[b][0] <= line_buf[b-1][PLANE_PIXELS-1];
        end
        for (int p = 1; p < PLANE_PIXELS; p++) begin
          line_buf[b][p] <= line_buf[b][p-1];
        end
      end
    end
  end

  // Fill count saturates once the chain is primed
  always_ff @(posedge clk) begin
    if (reset) begin
      fill_cnt <= '0;
      taps_valid_q <= 1'b0;
    end else if (in_valid_q) begin
      if (fill_cnt == FILL_CNT_WIDTH'(FILL_PIXELS)) begin
        taps_valid_q <= 1'b1;
      end else begin
        fill_cnt <= fill_cnt + 1'b1;
      end
    end
  end

  assign tap_bus = '{taps: taps_q, valid: taps_valid_q};

  a_pxl_known: assert property (
    @(posedge clk) disable iff (reset) valid_in |-> !$isunknown(pxl_in)
  );

endmodule

/* result_clamp.sv */
`timescale 1ns/1ps

module result_clamp
  import conv_geometry_pkg::*, conv_types_pkg::*;
(
  input  logic clk,
  input  logic reset,
  input  sum_t sum,
  input  logic sum_valid,
  output pxl_t pxl_out,
  output logic valid_out,
  output logic plane_last
);

  pxl_t clamped;
  logic [PIXEL_CNT_WIDTH-1:0] out_cnt;

  ////////////////////////////////////////
  // Saturation
  ////////////////////////////////////////

  always_comb begin
    if (sum > sum_t'(PXL_MAX)) begin
      clamped = PXL_MAX;
    end else if (sum < sum_t'(PXL_MIN)) begin
      clamped = PXL_MIN;
    end else begin
      clamped = pxl_t'(sum);
    end
  end

  always_ff @(posedge clk) begin
    if (sum_valid) begin
      pxl_out <= clamped;
    end
  end

  ////////////////////////////////////////
  // Output plane position
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      valid_out <= 1'b0;
      plane_last <= 1'b0;
      out_cnt <= '0;
    end else begin
      valid_out <= sum_valid;
      plane_last <= 1'b0;
      if (sum_valid) begin
        if (out_cnt == PIXEL_CNT_WIDTH'(PLANE_PIXELS - 1)) begin
          plane_last <= 1'b1;
          out_cnt <= '0;
        end else begin
          out_cnt <= out_cnt + 1'b1;
        end
      end
    end
  end

endmodule

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
  -f files.f --top-module tb_channel_adder

./obj_dir/Vtb_channel_adder | tee sim.log

if grep -qx "TESTBENCH PASSED" sim.log; then
  echo "Simulation passed"
else
  echo "Simulation failed"
  exit 1
fi

/* tb_channel_adder.sv */
`timescale 1ns/1ps

module tb_channel_adder
  import conv_geometry_pkg::*, conv_types_pkg::*;
();

  localparam int CLK_PERIOD = 40;
  localparam int RESET_CYCLES = 4;
  localparam int OUT_LATENCY = 4;
  localparam int MAX_GAP = 3;
  localparam int unsigned RAND_SEED = 19979;
  // Total of 48 + 64 + 64 + 64 + 128 + 192 strobes over all tests
  localparam int TOTAL_STROBES = 560;
  localparam int MARGIN_CYCLES = 400;
  localparam int WATCHDOG_NS = (TOTAL_STROBES * (MAX_GAP + 1) + MARGIN_CYCLES) * CLK_PERIOD;
  localparam int DRAIN_LIMIT = 40;

  // Expected result and the cycle it is due in
  typedef struct packed {
    pxl_t        value;
    logic [31:0] due_cycle;
  } expect_t;

  logic clk;
  logic reset;
  logic valid_in;
  pxl_t pxl_in;
  pxl_t pxl_out;
  logic valid_out;
  logic plane_last;

  pxl_t planes [CHANNEL_NUM][PLANE_PIXELS];
  int edge_vals [4] = '{20000, -20000, 8191, -8192};
  expect_t exp_q[$];
  logic [31:0] cycle_cnt = '0;
  int out_seen = 0;
  int last_seen = 0;
  int error_count = 0;
  int check_count = 0;
  int test_count = 0;
  int test_errors = 0;

  channel_adder_top dut_i (.*);

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
  end

  ////////////////////////////////////////
  // Checking and reference model
  ////////////////////////////////////////

  task automatic compare(input string what, input logic signed [31:0] got,
                         input logic signed [31:0] expected);
    check_count++;
    if (got !== expected) begin
      error_count++;
      $display("** Error at %0t: %s is %0d, expected %0d", $time, what, got, expected);
    end
  endtask

  function automatic pxl_t saturate(input int value);
    if (value > 32767) begin
      return pxl_t'(32767);
    end else if (value < -32768) begin
      return pxl_t'(-32768);
    end
    return pxl_t'(value);
  endfunction

  initial begin : monitor
    expect_t head;
    forever begin
      @(negedge clk);
      if (reset === 1'b0 && valid_out === 1'b1) begin
        if (exp_q.size() == 0) begin
          error_count++;
          $display("Unexpected output at %0t: valid_out set with no result due", $time);
        end else begin
          head = exp_q.pop_front();
          compare("pxl_out", 32'(pxl_out), 32'(head.value));
          compare("valid_out cycle", cycle_cnt, head.due_cycle);
          compare("plane_last", 32'(plane_last),
                  32'(out_seen % PLANE_PIXELS == PLANE_PIXELS - 1));
        end
        out_seen++;
        if (plane_last === 1'b1) begin
          last_seen++;
        end
      end else if (reset === 1'b0) begin
        compare("plane_last without valid_out", 32'(plane_last), 0);
      end
    end
  end

  ////////////////////////////////////////
  // Stimulus helpers
  ////////////////////////////////////////

  task automatic begin_test();
    @(negedge clk);
    reset = 1'b1;
    valid_in = 1'b0;
    repeat (RESET_CYCLES) @(negedge clk);
    reset = 1'b0;
    exp_q.delete();
    out_seen = 0;
    last_seen = 0;
    test_errors = error_count;
  endtask

  // 0 small ramps, 1 near the limits, 2 small random, 3 full range random
  task automatic fill_planes(input int kind);
    for (int c = 0; c < CHANNEL_NUM; c++) begin
      for (int p = 0; p < PLANE_PIXELS; p++) begin
        case (kind)
          0: planes[c][p] = pxl_t'(c * 100 + p);
          1: planes[c][p] = pxl_t'(edge_vals[p % 4]);
          2: planes[c][p] = pxl_t'(int'($urandom % 2001) - 1000);
          default: planes[c][p] = pxl_t'($urandom);
        endcase
      end
    end
  endtask

  task automatic send_planes(input int num_planes, input int max_gap);
    int gap;
    int total;
    expect_t entry;
    for (int c = 0; c < num_planes; c++) begin
      for (int p = 0; p < PLANE_PIXELS; p++) begin
        gap = int'($urandom % 32'(max_gap + 1));
        repeat (gap) begin
          @(negedge clk);
          valid_in = 1'b0;
        end
        @(negedge clk);
        valid_in = 1'b1;
        pxl_in = planes[c][p];
        if (c == CHANNEL_NUM - 1) begin
          total = 0;
          for (int k = 0; k < CHANNEL_NUM; k++) begin
            total += int'(planes[k][p]);
          end
          entry.value = saturate(total);
          // Sampled on the next rising edge
          entry.due_cycle = cycle_cnt + 32'(1 + OUT_LATENCY);
          exp_q.push_back(entry);
        end
      end
    end
  endtask

  task automatic end_test(input string name, input int groups);
    int waited;
    waited = 0;
    @(negedge clk);
    valid_in = 1'b0;
    while (exp_q.size() != 0 && waited < DRAIN_LIMIT) begin
      @(negedge clk);
      waited++;
    end
    if (exp_q.size() != 0) begin
      $display("Missing results in %s: %0d outputs never appeared", name, exp_q.size());
      error_count++;
      exp_q.delete();
    end
    // A few more idle cycles so stray outputs land in this test
    repeat (8) @(negedge clk);
    compare("output count", out_seen, groups * PLANE_PIXELS);
    compare("plane_last count", last_seen, groups);
    test_count++;
    if (error_count == test_errors) begin
      $display("%s: ok", name);
    end else begin
      $display("%s: %0d errors", name, error_count - test_errors);
    end
  endtask

  ////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////

  task automatic test_partial_group();
    begin_test();
    compare("valid_out after reset", 32'(valid_out), 0);
    compare("plane_last after reset", 32'(plane_last), 0);
    fill_planes(0);
    send_planes(CHANNEL_NUM - 1, 0);
    end_test("partial_group", 0);
  endtask

  task automatic test_single_group();
    begin_test();
    fill_planes(0);
    send_planes(CHANNEL_NUM, 0);
    end_test("single_group", 1);
  endtask

  task automatic test_saturation();
    begin_test();
    fill_planes(1);
    send_planes(CHANNEL_NUM, 0);
    end_test("saturation", 1);
  endtask

  task automatic test_idle_gaps();
    begin_test();
    fill_planes(2);
    send_planes(CHANNEL_NUM, MAX_GAP);
    end_test("idle_gaps", 1);
  endtask

  task automatic test_back_to_back();
    begin_test();
    fill_planes(2);
    send_planes(CHANNEL_NUM, 0);
    fill_planes(0);
    send_planes(CHANNEL_NUM, 0);
    end_test("back_to_back", 2);
  endtask

  task automatic test_random_groups();
    begin_test();
    repeat (3) begin
      fill_planes(3);
      send_planes(CHANNEL_NUM, 0);
    end
    end_test("random_groups", 3);
  endtask

  initial begin
    $timeformat(-9, 0, " ns", 0);
    void'($urandom(RAND_SEED));
    reset = 1'b1;
    valid_in = 1'b0;
    pxl_in = '0;
    test_partial_group();
    test_single_group();
    test_saturation();
    test_idle_gaps();
    test_back_to_back();
    test_random_groups();
    $display("Done: %0d tests, %0d checks, %0d errors", test_count, check_count, error_count);
    if (error_count == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

  initial begin : watchdog
    #(WATCHDOG_NS);
    $display("Timeout: the tests did not finish within %0d ns", WATCHDOG_NS);
    $display("TESTBENCH FAILED");
    $finish;
  end

endmodule
